/* build.f */
+incdir+verilog
verilog/cp0_pkg.sv
verilog/cp0_trap_if.sv
verilog/cp0_irq_sync.sv
verilog/cp0_exc_arbiter.sv
verilog/cp0_regs.sv
verilog/cp0_top.sv
dv/cp0_clk_gen.sv
dv/cp0_chk.sv
dv/cp0_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the CP0 testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module cp0_tb \
	-f build.f \
	--Mdir obj_dir -o cp0_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see $BUILD_LOG"
	exit 1
fi

./obj_dir/cp0_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Test completed successfully" "$SIM_LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

/* dv/cp0_tb.sv */
`timescale 1ns/1ps
`include "cp0_defines.svh"

module cp0_tb;
	import cp0_pkg::*;

	localparam int P1_ITERS    = 24;
	localparam int P3_CYCLES   = 48;
	localparam int TEST_CYCLES = 3 * P1_ITERS + P3_CYCLES + 120;  // rough sum of all phases

	// software copy of the cp0 state
	typedef struct packed {
		logic [31:0] status;
		logic [4:0]  exc_code;
		logic [1:0]  sw_ip;
		logic [31:0] epc;
		logic [31:0] count;
		logic [31:0] compare;
		logic        tp;  // timer pending
		logic [5:0]  s1;  // irq sync stages
		logic [5:0]  s2;
	} model_t;

	logic clk, reset;
	cp0_addr_e rd_addr, wr_addr;
	cp0_word_t rd_data, wr_data, pipe_pc, redirect_pc;
	logic wr_en, exc_valid, eret, intr, redirect_valid;
	exc_code_e exc_code;
	logic [`CP0_NUM_IRQ-1:0] irq;
	model_t mdl;
	int err_cnt = 0;
	logic [31:0] rnd;

	cp0_clk_gen u_clk_gen (.clk(clk), .reset(reset));

	cp0_top UUT (
		.clk(clk), .reset(reset), .rd_addr(rd_addr), .rd_data(rd_data),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.exc_valid(exc_valid), .exc_code(exc_code), .pipe_pc(pipe_pc), .eret(eret),
		.irq(irq), .intr(intr), .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
	);

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic model_t reset_state();
		model_t m;
		m = '0;
		m.status  = `CP0_STATUS_RST;
		m.compare = `CP0_COMPARE_RST;
		return m;
	endfunction

	// ip[7] ors hw line 5 with the timer and ip[1:0] are the software bits
	function automatic logic [7:0] pending_ip(model_t m);
		return {m.s2[5] | m.tp, m.s2[4:0], m.sw_ip};
	endfunction

	function automatic logic expected_intr(model_t m);
		return m.status[0] && !m.status[1] && (|(m.status[15:8] & pending_ip(m)));
	endfunction

	function automatic logic [31:0] read_value(model_t m, logic [4:0] a);
		case (a)
			CP0_COUNT:   return m.count;
			CP0_COMPARE: return m.compare;
			CP0_STATUS:  return m.status;
			CP0_CAUSE:   return {16'h0, pending_ip(m), 1'b0, m.exc_code, 2'b00};
			CP0_EPC:     return m.epc;
			default:     return 32'h0;
		endcase
	endfunction

	// state after the next rising edge
	function automatic model_t model_next(model_t m, logic we, logic [4:0] wa,
			logic [31:0] wd, logic ev, logic [4:0] ec, logic [31:0] pc, logic er,
			logic [5:0] irq_in);
		model_t n = m;
		logic take;
		take = ev || expected_intr(m);  // exception or masked interrupt
		n.s1 = irq_in;
		n.s2 = m.s1;
		n.count = (we && wa == CP0_COUNT) ? wd : m.count + 32'd1;
		if (we && wa == CP0_COMPARE) begin
			n.compare = wd;
			n.tp = 1'b0;  // compare write acks the timer
		end else if (m.count == m.compare) begin
			n.tp = 1'b1;
		end
		if (take) begin
			n.status[1] = 1'b1;
			n.exc_code  = ev ? ec : 5'd0;
			n.epc       = pc;  // mtc0 in this cycle is lost
		end else begin
			if (er)
				n.status[1] = 1'b0;
			else if (we && wa == CP0_STATUS)
				n.status = wd;
			if (we && wa == CP0_CAUSE)
				n.sw_ip = wd[9:8];
			if (we && wa == CP0_EPC)
				n.epc = wd;
		end
		return n;
	endfunction

	task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
		if (exp !== act) begin
			err_cnt++;
			$display("Error: %s expected %h actual %h at %0t", name, exp, act, $time);
		end
	endtask

	//////////////////////////////
	// compare process
	//////////////////////////////

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		logic exp_take;
		if (reset) begin
			mdl = reset_state();
		end else begin
			exp_take = exc_valid || expected_intr(mdl);
			check_val("rd_data", read_value(mdl, rd_addr), rd_data);
			check_val("intr", {31'd0, expected_intr(mdl)}, {31'd0, intr});
			check_val("redirect_valid", {31'd0, exp_take || eret}, {31'd0, redirect_valid});
			if (exp_take || eret)
				check_val("redirect_pc", exp_take ? `CP0_EXC_VECTOR : mdl.epc, redirect_pc);
			mdl = model_next(mdl, wr_en, wr_addr, wr_data, exc_valid, exc_code, pipe_pc,
				eret, irq);
		end
	end

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	// waits to 1 ns past the edge and drops the strobes
	task automatic next_cycle();
		@(posedge clk);
		#1;
		wr_en     = 1'b0;
		exc_valid = 1'b0;
		eret      = 1'b0;
	endtask

	task automatic write_reg(cp0_addr_e a, logic [31:0] d);
		next_cycle();
		wr_en   = 1'b1;
		wr_addr = a;
		wr_data = d;
	endtask

	task automatic raise_exc(exc_code_e c, logic [31:0] pc);
		next_cycle();
		exc_valid = 1'b1;
		exc_code  = c;
		pipe_pc   = pc;
	endtask

	task automatic return_from_exc();
		next_cycle();
		eret = 1'b1;
	endtask

	// watchdog
	initial begin
		#((TEST_CYCLES + 100) * 10);
		$display("timeout, stimulus did not finish, errors: %0d", err_cnt);
		$display("Test failed");
		$finish;
	end

	initial begin
		rd_addr = CP0_STATUS;
		wr_addr = CP0_STATUS;
		wr_data = '0;
		wr_en = 1'b0;
		exc_valid = 1'b0;
		exc_code = EXC_INT;
		pipe_pc = '0;
		eret = 1'b0;
		irq = '0;
		rnd = $urandom(52);
		@(negedge reset);

		// register access with im kept clear so nothing traps
		for (int i = 0; i < P1_ITERS; i++) begin
			rnd = $urandom();
			case (rnd[2:0])
				3'd0: rd_addr = CP0_COUNT;
				3'd1: rd_addr = CP0_COMPARE;
				3'd2: rd_addr = CP0_STATUS;
				3'd3: rd_addr = CP0_CAUSE;
				3'd4: rd_addr = CP0_EPC;
				default: rd_addr = cp0_addr_e'(rnd[7:3]);  // mostly unmapped
			endcase
			rnd = $urandom();
			write_reg(rd_addr, (rd_addr == CP0_STATUS) ? (rnd & 32'hffff_00ff) : rnd);
			next_cycle();
			next_cycle();  // count moves on
		end

		// syscall, break and overflow with an eret after each
		write_reg(CP0_STATUS, 32'h0000_0001);
		for (int c = 0; c < 3; c++) begin
			rnd = $urandom();
			rd_addr = CP0_EPC;
			raise_exc((c == 0) ? EXC_SYS : (c == 1) ? EXC_BP : EXC_OV, rnd & 32'hffff_fffc);
			next_cycle();
			rd_addr = CP0_CAUSE;
			next_cycle();
			rd_addr = CP0_STATUS;
			return_from_exc();
			next_cycle();
		end

		// random irq lines against random ie, exl, im and sw bits
		for (int i = 0; i < P3_CYCLES; i++) begin
			rnd = $urandom();
			next_cycle();
			irq = rnd[5:0];
			rd_addr = CP0_CAUSE;
			if (rnd[7:6] == 2'd0) begin
				wr_en = 1'b1;
				wr_addr = CP0_STATUS;
				wr_data = {16'h0, rnd[15:8], 6'h0, rnd[17:16]};
			end else if (rnd[7:6] == 2'd1) begin
				wr_en = 1'b1;
				wr_addr = CP0_CAUSE;
				wr_data = {22'h0, rnd[19:18], 8'h0};
			end
		end
		irq = '0;
		write_reg(CP0_CAUSE, 32'h0);
		write_reg(CP0_STATUS, 32'h0000_0101);
		write_reg(CP0_CAUSE, 32'h0000_0100);  // sw ip0 alone raises intr
		repeat (3) next_cycle();

		// timer with ie off so ip[7] just sits in cause
		write_reg(CP0_STATUS, 32'h0);
		write_reg(CP0_COUNT, 32'h0000_0100);
		write_reg(CP0_COMPARE, 32'h0000_0108);
		rd_addr = CP0_CAUSE;
		repeat (12) next_cycle();
		write_reg(CP0_COMPARE, 32'hffff_0000);  // clears ip[7]
		repeat (3) next_cycle();

		// priority cases with sw ip0 pending
		write_reg(CP0_CAUSE, 32'h0000_0100);
		write_reg(CP0_STATUS, 32'h0000_ff01);
		raise_exc(EXC_OV, 32'h0000_4000);  // beats the interrupt
		next_cycle();
		write_reg(CP0_STATUS, 32'h0000_ff01);
		pipe_pc = 32'h0000_5000;  // pc the interrupt trap saves
		return_from_exc();  // intr wins over eret
		write_reg(CP0_STATUS, 32'h0000_ff01);
		pipe_pc = 32'h0000_6000;
		rd_addr = CP0_EPC;
		write_reg(CP0_EPC, 32'hdead_beec);  // lost to the take
		next_cycle();
		write_reg(CP0_STATUS, 32'h0);
		write_reg(CP0_CAUSE, 32'h0);
		repeat (3) next_cycle();

		@(posedge clk);
		$display("errors: %0d", err_cnt);
		if (err_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* dv/cp0_chk.sv */
`timescale 1ns/1ps
`include "cp0_defines.svh"

// protocol rules on the trap bus and the interrupt request
module cp0_chk (
	input logic clk,
	input logic reset,
	input logic take,
	input logic eret,
	input logic exl,
	input logic intr,
	input logic redirect_valid
);

	//////////////////////////////
	// trap bus
	//////////////////////////////

	// arbiter picks one of the two
	a_take_eret_excl: assert property (@(posedge clk) disable iff (reset)
		!(take && eret)) else $error("take and eret high in the same cycle");

	// handler entry latches exl
	a_exl_after_take: assert property (@(posedge clk) disable iff (reset)
		take |=> exl) else $error("exl not set one cycle after a trap");

	//////////////////////////////
	// reset and masking
	//////////////////////////////

	// once a reset edge has passed, no redirect while reset is held
	a_no_redirect_in_reset: assert property (@(posedge clk)
		reset |=> (!reset || !redirect_valid)) else $error("redirect during reset");

	a_no_intr_in_handler: assert property (@(posedge clk) disable iff (reset)
		exl |-> !intr) else $error("intr high while exl is set");

endmodule

bind cp0_top cp0_chk u_chk (
	.clk            (clk),
	.reset          (reset),
	.take           (trap_bus.take),
	.eret           (trap_bus.eret),
	.exl            (u_regs.status[`CP0_ST_EXL]),
	.intr           (intr),
	.redirect_valid (redirect_valid)
);

/* dv/cp0_clk_gen.sv */
`timescale 1ns/1ps

// 10 ns clock, reset held over the first two rising edges
module cp0_clk_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;  // released with the stimulus skew
	end

endmodule

/* verilog/cp0_top.sv */
`timescale 1ns/1ps
`include "cp0_defines.svh"

// cp0 subsystem, pipeline facing ports
module cp0_top (
	input  logic                    clk,
	input  logic                    reset,
	// mfc0
	input  cp0_pkg::cp0_addr_e      rd_addr,
	output cp0_pkg::cp0_word_t      rd_data,
	// mtc0
	input  logic                    wr_en,
	input  cp0_pkg::cp0_addr_e      wr_addr,
	input  cp0_pkg::cp0_word_t      wr_data,
	// precise exceptions and eret
	input  logic                    exc_valid,
	input  cp0_pkg::exc_code_e      exc_code,
	input  cp0_pkg::cp0_word_t      pipe_pc,
	input  logic                    eret,
	// device lines
	input  logic [`CP0_NUM_IRQ-1:0] irq,
	output logic                    intr,
	// fetch redirect
	output logic                    redirect_valid,
	output cp0_pkg::cp0_word_t      redirect_pc
);
	import cp0_pkg::*;

	logic [`CP0_NUM_IRQ-1:0] irq_sync;
	cp0_word_t epc;  // return target, regs to arbiter

	cp0_trap_if trap_bus ();

	cp0_irq_sync u_irq_sync (
		.clk       (clk),
		.reset     (reset),
		.irq_async (irq),
		.irq_sync  (irq_sync)
	);

	cp0_exc_arbiter u_exc_arbiter (
		.exc_valid      (exc_valid),
		.exc_code       (exc_code),
		.pipe_pc        (pipe_pc),
		.eret           (eret),
		.intr           (intr),
		.epc            (epc),
		.trap           (trap_bus.arb),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

	cp0_regs u_regs (
		.clk     (clk),
		.reset   (reset),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.irq     (irq_sync),
		.trap    (trap_bus.regs),
		.intr    (intr),  // also the arbiter's input
		.epc     (epc)
	);

endmodule

/* verilog/cp0_regs.sv */
`timescale 1ns/1ps
`include "cp0_defines.svh"

// status, cause, epc, count, compare and the interrupt request
module cp0_regs (
	input  logic                    clk,
	input  logic                    reset,
	input  cp0_pkg::cp0_addr_e      rd_addr,   // mfc0 source
	output cp0_pkg::cp0_word_t      rd_data,
	input  logic                    wr_en,     // mtc0 in write back
	input  cp0_pkg::cp0_addr_e      wr_addr,
	input  cp0_pkg::cp0_word_t      wr_data,
	input  logic [`CP0_NUM_IRQ-1:0] irq,       // already synchronized
	cp0_trap_if.regs                trap,
	output logic                    intr,
	output cp0_pkg::cp0_word_t      epc
);
	import cp0_pkg::*;

	localparam cp0_word_t CAUSE_RST = `CP0_CAUSE_RST;
	localparam int        IP_W      = `CP0_CA_IP_HI - `CP0_CA_IP_LO + 1;

	cp0_word_t status;
	cp0_word_t count;
	cp0_word_t compare;
	cp0_word_t cause;          // assembled, not a flop
	logic [1:0] sw_ip;         // cause ip[1:0], software interrupts
	exc_code_e exc_code;       // cause[6:2]
	logic timer_pending;
	logic [IP_W-1:0] ip;
	logic [IP_W-1:0] im;

	logic wr_status;
	logic wr_cause;
	logic wr_epc;
	logic wr_count;
	logic wr_compare;

	// mtc0 decode
	assign wr_status  = wr_en && (wr_addr == CP0_STATUS);
	assign wr_cause   = wr_en && (wr_addr == CP0_CAUSE);
	assign wr_epc     = wr_en && (wr_addr == CP0_EPC);
	assign wr_count   = wr_en && (wr_addr == CP0_COUNT);
	assign wr_compare = wr_en && (wr_addr == CP0_COMPARE);

	//////////////////////////////
	// pending bits and intr
	//////////////////////////////

	// timer shares ip[7] with the top hw line
	assign ip = {irq[`CP0_NUM_IRQ-1] | timer_pending, irq[`CP0_NUM_IRQ-2:0], sw_ip};
	assign im = status[`CP0_ST_IM_HI:`CP0_ST_IM_LO];

	// nothing while in a handler
	assign intr = status[`CP0_ST_IE] & ~status[`CP0_ST_EXL] & (|(im & ip));

	always_comb begin
		cause = '0;
		cause[`CP0_CA_IP_HI:`CP0_CA_IP_LO]   = ip;
		cause[`CP0_CA_EXC_HI:`CP0_CA_EXC_LO] = exc_code;
	end

	//////////////////////////////
	// status
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			status <= `CP0_STATUS_RST;
		end else if (trap.take) begin
			status[`CP0_ST_EXL] <= 1'b1;  // enter handler
		end else if (trap.eret) begin
			status[`CP0_ST_EXL] <= 1'b0;  // back to user code
		end else if (wr_status) begin
			status <= wr_data;  // whole word
		end
	end

	//////////////////////////////
	// cause and epc
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			exc_code <= exc_code_e'(CAUSE_RST[`CP0_CA_EXC_HI:`CP0_CA_EXC_LO]);
			sw_ip    <= CAUSE_RST[`CP0_CA_IP_LO+1:`CP0_CA_IP_LO];
		end else if (trap.take) begin
			exc_code <= trap.code;  // mtc0 to cause lost this cycle
		end else if (wr_cause) begin
			sw_ip <= wr_data[`CP0_CA_IP_LO+1:`CP0_CA_IP_LO];  // rest read only
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			epc <= '0;
		end else if (trap.take) begin
			epc <= trap.epc;
		end else if (wr_epc) begin
			epc <= wr_data;
		end
	end

	//////////////////////////////
	// timer
	//////////////////////////////

	// free running, a load restarts from the new value
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (wr_count) begin
			count <= wr_data;
		end else begin
			count <= count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			compare <= `CP0_COMPARE_RST;
		end else if (wr_compare) begin
			compare <= wr_data;
		end
	end

	// sticky until software rewrites compare
	always_ff @(posedge clk) begin
		if (reset) begin
			timer_pending <= 1'b0;
		end else if (wr_compare) begin
			timer_pending <= 1'b0;  // ack
		end else if (count == compare) begin
			timer_pending <= 1'b1;
		end
	end

	//////////////////////////////
	// mfc0 read mux
	//////////////////////////////

	always_comb begin
		case (rd_addr)
			CP0_STATUS:  rd_data = status;
			CP0_CAUSE:   rd_data = cause;
			CP0_EPC:     rd_data = epc;
			CP0_COUNT:   rd_data = count;
			CP0_COMPARE: rd_data = compare;
			default:     rd_data = '0;  // unmapped reads zero
		endcase
	end

endmodule

/* verilog/cp0_exc_arbiter.sv */
`timescale 1ns/1ps
`include "cp0_defines.svh"

// one trap decision per cycle plus the fetch redirect
module cp0_exc_arbiter (
	input  logic                  exc_valid,  // precise exception from pipe
	input  cp0_pkg::exc_code_e    exc_code,
	input  cp0_pkg::cp0_word_t    pipe_pc,    // pc of the faulting / interrupted insn
	input  logic                  eret,
	input  logic                  intr,       // already masked by ie/exl/im
	input  cp0_pkg::cp0_word_t    epc,        // return target for eret
	cp0_trap_if.arb               trap,
	output logic                  redirect_valid,
	output cp0_pkg::cp0_word_t    redirect_pc
);
	import cp0_pkg::*;

	localparam cp0_word_t EXC_VECTOR = `CP0_EXC_VECTOR;

	//////////////////////////////
	// fixed priority
	//////////////////////////////

	// exception beats interrupt beats eret
	always_comb begin
		trap.take = 1'b0;
		trap.code = EXC_INT;
		trap.epc  = pipe_pc;  // both trap kinds save the same pc
		trap.eret = 1'b0;
		if (exc_valid) begin
			trap.take = 1'b1;
			trap.code = exc_code;
		end else if (intr) begin
			trap.take = 1'b1;
			trap.code = EXC_INT;
		end else if (eret) begin
			trap.eret = 1'b1;  // eret squashed when anything traps
		end
	end

	//////////////////////////////
	// fetch redirect
	//////////////////////////////

	// no stall path, pipe must take this now
	assign redirect_valid = trap.take | trap.eret;
	assign redirect_pc    = trap.take ? EXC_VECTOR : epc;  // eret goes back to epc

endmodule

/* verilog/cp0_irq_sync.sv */
`timescale 1ns/1ps
`include "cp0_defines.svh"

// device irq lines come from other clock domains
module cp0_irq_sync (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [`CP0_NUM_IRQ-1:0] irq_async,
	output logic [`CP0_NUM_IRQ-1:0] irq_sync
);

	logic [`CP0_NUM_IRQ-1:0] meta;  // first stage, may go metastable
	logic [`CP0_NUM_IRQ-1:0] stable;  // second stage

	//////////////////////////////
	// two flop chain per line
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			meta   <= '0;
			stable <= '0;
		end else begin
			meta   <= irq_async;
			stable <= meta;  // settled by now
		end
	end

	// visible to cause ip two edges after the pin moves
	assign irq_sync = stable;

endmodule

/* verilog/cp0_trap_if.sv */
`timescale 1ns/1ps

// trap decision from the arbiter into the register file
interface cp0_trap_if;
	import cp0_pkg::*;

	logic      take;  // trap taken this cycle, one cycle strobe
	exc_code_e code;  // what gets written into cause
	cp0_word_t epc;   // pc to save
	logic      eret;  // drop exl this cycle

	// arbiter drives everything
	modport arb (
		output take,
		output code,
		output epc,
		output eret
	);

	// register file only listens
	modport regs (
		input take,
		input code,
		input epc,
		input eret
	);

endinterface

/* verilog/cp0_pkg.sv */
`include "cp0_defines.svh"

package cp0_pkg;

	//////////////////////////////
	// data word
	//////////////////////////////

	typedef logic [`CP0_DATA_W-1:0] cp0_word_t;

	//////////////////////////////
	// register numbers
	//////////////////////////////

	// mfc0/mtc0 rd field, only the mapped ones
	typedef enum logic [4:0] {
		CP0_COUNT   = 5'd9,
		CP0_COMPARE = 5'd11,
		CP0_STATUS  = 5'd12,
		CP0_CAUSE   = 5'd13,
		CP0_EPC     = 5'd14
	} cp0_addr_e;

	//////////////////////////////
	// exception codes
	//////////////////////////////

	// goes into cause[6:2]
	typedef enum logic [4:0] {
		EXC_INT = 5'd0,  // external or timer interrupt
		EXC_SYS = 5'd8,  // syscall
		EXC_BP  = 5'd9,  // break
		EXC_OV  = 5'd12  // arithmetic overflow
	} exc_code_e;

endpackage

/* verilog/cp0_defines.svh */
`ifndef CP0_DEFINES_SVH
`define CP0_DEFINES_SVH

`define CP0_DATA_W       32
`define CP0_NUM_IRQ      6              // hw lines, land on ip[7:2]
`define CP0_EXC_VECTOR   32'h0000_0180  // general handler entry

// reset values
`define CP0_STATUS_RST   32'h0000_0001  // ie only
`define CP0_CAUSE_RST    32'h0000_0000
`define CP0_COMPARE_RST  32'hffff_ffff

// status fields
`define CP0_ST_IE        0
`define CP0_ST_EXL       1
`define CP0_ST_IM_HI     15
`define CP0_ST_IM_LO     8

// cause fields
`define CP0_CA_EXC_HI    6
`define CP0_CA_EXC_LO    2
`define CP0_CA_IP_HI     15
`define CP0_CA_IP_LO     8

`endif
